//--- verilog.f
mem_pkg.sv
mem_ram_if.sv
mem_read_port.sv
mem_write_port.sv
mem_store.sv
mem_top.sv
mem_tb_assert.sv
mem_tb.sv

//--- mem_tb.sv
`timescale 1ns/1ps

module mem_tb;

    // about 150 transactions at up to 20 cycles each
    localparam int max_cycles = 3000;

    int          seed = 32'h087866d0;
    int          cycles = 0;
    int          hang_count = 0;
    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic [31:0] imem_araddr = '0, dmem_araddr = '0, dmem_awaddr = '0, dmem_wdata = '0;
    logic [3:0]  dmem_wmask = '0;
    logic        imem_arvalid = 1'b0, dmem_arvalid = 1'b0, dmem_awvalid = 1'b0;
    logic        dmem_wvalid = 1'b0, dmem_wen = 1'b0;
    logic        imem_rready = 1'b0, dmem_rready = 1'b0, dmem_bready = 1'b0;
    logic [2:0]  stall_draw;
    logic [31:0] imem_rdata, dmem_rdata;
    logic [1:0]  imem_rresp, dmem_rresp, dmem_bresp;
    logic        imem_arready, imem_rvalid, dmem_arready, dmem_rvalid;
    logic        dmem_awready, dmem_wready, dmem_bvalid;

    mem_top dut (.*);

    always #10 clk = !clk;

    // random stalls on the R and B channels
    always @(posedge clk) begin
        // drawn on the edge, ahead of the stimulus draws
        stall_draw = 3'($random(seed));
        #1;
        imem_rready = stall_draw[0];
        dmem_rready = stall_draw[1];
        dmem_bready = stall_draw[2];
    end

    // split: W follows one cycle after AW fires, otherwise both together
    task automatic write_word(input logic split, input logic [31:0] a, d,
                              input logic [3:0] mask, input logic en);
        dmem_awaddr  = a;
        dmem_wdata   = d;
        dmem_wmask   = mask;
        dmem_wen     = en;
        dmem_awvalid = 1'b1;
        dmem_wvalid  = !split;
        @(negedge clk);
        while (!dmem_awready) @(negedge clk);
        @(posedge clk);
        #1;
        dmem_awvalid = 1'b0;
        if (split) begin
            dmem_wvalid = 1'b1;
            @(negedge clk);
            while (!dmem_wready) @(negedge clk);
            @(posedge clk);
            #1;
        end
        dmem_wvalid = 1'b0;
        @(negedge clk);
        while (!(dmem_bvalid && dmem_bready)) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    // both read channels at once, each answers on its own
    task automatic read_pair(input logic [31:0] ia, da);
        imem_araddr  = ia;
        dmem_araddr  = da;
        imem_arvalid = 1'b1;
        dmem_arvalid = 1'b1;
        @(negedge clk);
        while (!(imem_arready && dmem_arready)) @(negedge clk);
        @(posedge clk);
        #1;
        imem_arvalid = 1'b0;
        dmem_arvalid = 1'b0;
        fork
            begin
                @(negedge clk);
                while (!(imem_rvalid && imem_rready)) @(negedge clk);
            end
            begin
                @(negedge clk);
                while (!(dmem_rvalid && dmem_rready)) @(negedge clk);
            end
        join
        @(posedge clk);
        #1;
    endtask

    task automatic finish_run();
        $display("assertion errors: %0d, timeouts: %0d", dut.chk.err_count, hang_count);
        if (dut.chk.err_count == 0 && hang_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == max_cycles) begin
            hang_count++;
            $display("timeout after %0d cycles, a handshake never completed", cycles);
            finish_run();
        end
    end

    initial begin
        logic [31:0] a;
        logic [2:0]  op;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        // known contents in the 16 words under test
        for (int i = 0; i < 16; i++) begin
            write_word(1'(i), mem_pkg::mem_base + 32'(4 * i), $random(seed), 4'hf, 1'b1);
        end
        for (int n = 0; n < 120; n++) begin
            a  = mem_pkg::mem_base + 32'($random(seed) & 63);
            op = 3'($random(seed));
            case (op)
                3'd0, 3'd1: write_word(op[0], a, $random(seed), 4'($random(seed)), 1'b1);
                // wen low, or an empty mask
                3'd2: write_word(1'b1, a, $random(seed), n[0] ? 4'h0 : 4'hf, n[0]);
                // one window past the ram, same word index
                3'd3: write_word(1'b0, a + 32'h400, $random(seed), 4'hf, 1'b1);
                3'd6: read_pair(a + 32'h400, a);
                3'd7: read_pair(a, a - mem_pkg::mem_base);
                default: read_pair(a, a ^ 32'h3c);
            endcase
        end
        finish_run();
    end

endmodule

//--- mem_tb_assert.sv
`timescale 1ns/1ps

module mem_tb_assert (
    input logic        clk,
    input logic        rst,
    input logic [31:0] imem_araddr, imem_rdata, dmem_araddr, dmem_rdata,
    input logic [31:0] dmem_awaddr, dmem_wdata,
    input logic [1:0]  imem_rresp, dmem_rresp, dmem_bresp,
    input logic [3:0]  dmem_wmask,
    input logic        imem_arvalid, imem_arready, imem_rvalid, imem_rready,
    input logic        dmem_arvalid, dmem_arready, dmem_rvalid, dmem_rready,
    input logic        dmem_awvalid, dmem_awready, dmem_wvalid, dmem_wready,
    input logic        dmem_wen, dmem_bvalid, dmem_bready
);

    int          err_count = 0;
    int          lane;
    logic [31:0] shadow [256];
    logic [31:0] aw_addr, waddr, imem_exp, dmem_exp;
    logic [1:0]  imem_eresp, dmem_eresp, exp_bresp;
    logic        aw_held, imem_ar, dmem_ar, aw_hs, w_hs;

    // 1 KiB window starting at the base
    function automatic logic in_window(input logic [31:0] a);
        return (a - mem_pkg::mem_base) < 32'd1024;
    endfunction

    task automatic report_fail(input string msg);
        err_count++;
        $error("Fail %0t: %s", $time, msg);
    endtask

    assign imem_ar = imem_arvalid && imem_arready;
    assign dmem_ar = dmem_arvalid && dmem_arready;
    assign aw_hs   = dmem_awvalid && dmem_awready;
    assign w_hs    = dmem_wvalid && dmem_wready;
    assign waddr   = aw_held ? aw_addr : dmem_awaddr;
    assign lane    = 32'(waddr[1:0]);

    always @(posedge clk) begin
        aw_addr <= aw_hs ? dmem_awaddr : aw_addr;
        aw_held <= !rst && !w_hs && (aw_hs || aw_held);
        if (w_hs) begin
            exp_bresp <= in_window(waddr) ? mem_pkg::resp_okay : mem_pkg::resp_slverr;
        end
        // lanes shifted past lane 3 fall off
        if (w_hs && dmem_wen && in_window(waddr)) begin
            for (int i = 0; i < 4; i++) begin
                if (i >= lane && dmem_wmask[i - lane]) begin
                    shadow[waddr[9:2]][8*i +: 8] <= dmem_wdata[8*(i - lane) +: 8];
                end
            end
        end
        // a read sees the word as it was before this edge
        if (imem_ar) begin
            imem_exp   <= in_window(imem_araddr) ? shadow[imem_araddr[9:2]] : 32'h0;
            imem_eresp <= in_window(imem_araddr) ? mem_pkg::resp_okay : mem_pkg::resp_slverr;
        end
        if (dmem_ar) begin
            dmem_exp   <= in_window(dmem_araddr) ? shadow[dmem_araddr[9:2]] : 32'h0;
            dmem_eresp <= in_window(dmem_araddr) ? mem_pkg::resp_okay : mem_pkg::resp_slverr;
        end
    end

    assert property (@(posedge clk) disable iff (rst) imem_ar |=>
        (!imem_rvalid && !imem_arready) [*2] ##1 imem_rvalid)
        else report_fail("imem rvalid not two cycles after the AR handshake");
    assert property (@(posedge clk) disable iff (rst) dmem_ar |=>
        (!dmem_rvalid && !dmem_arready) [*2] ##1 dmem_rvalid)
        else report_fail("dmem rvalid not two cycles after the AR handshake");
    assert property (@(posedge clk) disable iff (rst) imem_rvalid |->
        !imem_arready && imem_rdata === imem_exp && imem_rresp == imem_eresp)
        else report_fail("imem read response differs from the shadow memory");
    assert property (@(posedge clk) disable iff (rst) dmem_rvalid |->
        !dmem_arready && dmem_rdata === dmem_exp && dmem_rresp == dmem_eresp)
        else report_fail("dmem read response differs from the shadow memory");
    assert property (@(posedge clk) disable iff (rst)
        imem_rvalid && !imem_rready |=> imem_rvalid)
        else report_fail("imem rvalid dropped before rready");
    assert property (@(posedge clk) disable iff (rst)
        dmem_rvalid && !dmem_rready |=> dmem_rvalid)
        else report_fail("dmem rvalid dropped before rready");
    assert property (@(posedge clk) disable iff (rst) w_hs |=> dmem_bvalid)
        else report_fail("bvalid not one cycle after the W handshake");
    assert property (@(posedge clk) disable iff (rst) dmem_bvalid |->
        !dmem_awready && !dmem_wready && dmem_bresp == exp_bresp)
        else report_fail("write response wrong or AW/W ready while bvalid");
    assert property (@(posedge clk) disable iff (rst)
        dmem_bvalid && !dmem_bready |=> dmem_bvalid)
        else report_fail("bvalid dropped before bready");

endmodule

bind mem_top mem_tb_assert chk (.*);

//--- mem_top.sv
`timescale 1ns/1ps

module mem_top (
    input  logic        clk,
    input  logic        rst,

    // imem
    input  logic [31:0] imem_araddr,
    input  logic        imem_arvalid,
    output logic        imem_arready,
    output logic [31:0] imem_rdata,
    output logic [1:0]  imem_rresp,
    output logic        imem_rvalid,
    input  logic        imem_rready,

    // dmem read
    input  logic [31:0] dmem_araddr,
    input  logic        dmem_arvalid,
    output logic        dmem_arready,
    output logic [31:0] dmem_rdata,
    output logic [1:0]  dmem_rresp,
    output logic        dmem_rvalid,
    input  logic        dmem_rready,

    // dmem write
    input  logic [31:0] dmem_awaddr,
    input  logic        dmem_awvalid,
    output logic        dmem_awready,
    input  logic [31:0] dmem_wdata,
    input  logic [3:0]  dmem_wmask,
    input  logic        dmem_wen,
    input  logic        dmem_wvalid,
    output logic        dmem_wready,
    output logic [1:0]  dmem_bresp,
    output logic        dmem_bvalid,
    input  logic        dmem_bready
);

    mem_ram_if ram_imem ();
    mem_ram_if ram_dmem_rd ();
    mem_ram_if ram_dmem_wr ();

    mem_read_port u_imem (
        .clk(clk), .rst(rst),
        .araddr(imem_araddr), .arvalid(imem_arvalid), .arready(imem_arready),
        .rdata(imem_rdata), .rresp(imem_rresp),
        .rvalid(imem_rvalid), .rready(imem_rready),
        .ram(ram_imem.ctrl)
    );

    mem_read_port u_dmem_rd (
        .clk(clk), .rst(rst),
        .araddr(dmem_araddr), .arvalid(dmem_arvalid), .arready(dmem_arready),
        .rdata(dmem_rdata), .rresp(dmem_rresp),
        .rvalid(dmem_rvalid), .rready(dmem_rready),
        .ram(ram_dmem_rd.ctrl)
    );

    mem_write_port u_dmem_wr (
        .clk(clk), .rst(rst),
        .awaddr(dmem_awaddr), .awvalid(dmem_awvalid), .awready(dmem_awready),
        .wdata(dmem_wdata), .wmask(dmem_wmask), .wen(dmem_wen),
        .wvalid(dmem_wvalid), .wready(dmem_wready),
        .bresp(dmem_bresp), .bvalid(dmem_bvalid), .bready(dmem_bready),
        .ram(ram_dmem_wr.ctrl)
    );

    mem_store u_store (
        .clk(clk),
        .imem(ram_imem.ram),
        .dmem_rd(ram_dmem_rd.ram),
        .dmem_wr(ram_dmem_wr.ram)
    );

endmodule

//--- mem_store.sv
`timescale 1ns/1ps

module mem_store (
    input  logic   clk,
    mem_ram_if.ram imem,
    mem_ram_if.ram dmem_rd,
    mem_ram_if.ram dmem_wr
);

    mem_pkg::store_word_u mem [mem_pkg::mem_words];

    // instruction read port
    always_ff @(posedge clk) begin
        if (imem.en) begin
            imem.rdata <= mem[imem.addr].word;
        end
    end

    // data read port
    always_ff @(posedge clk) begin
        if (dmem_rd.en) begin
            dmem_rd.rdata <= mem[dmem_rd.addr].word;
        end
    end

    // byte-strobed write, reads on the same edge see the old word
    always_ff @(posedge clk) begin
        if (dmem_wr.we) begin
            for (int i = 0; i < 4; i++) begin
                if (dmem_wr.wstrb[i]) begin
                    mem[dmem_wr.addr].lanes[i] <= dmem_wr.wdata.lanes[i];
                end
            end
        end
    end

    // write-only port
    assign dmem_wr.rdata = 32'h0;

endmodule

//--- mem_write_port.sv
`timescale 1ns/1ps

module mem_write_port (
    input  logic        clk,
    input  logic        rst,

    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,

    input  logic [31:0] wdata,
    input  logic [3:0]  wmask,
    input  logic        wen,
    input  logic        wvalid,
    output logic        wready,

    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,

    mem_ram_if.ctrl     ram
);

    logic [31:0]          awaddr_latched;
    logic                 awaddr_held;
    logic                 aw_fire;
    logic                 w_fire;
    logic [31:0]          waddr_use;
    logic [1:0]           lane_ofs;
    logic                 addr_ok;
    mem_pkg::store_word_u wdata_aligned;

    // one write response outstanding at a time
    assign awready = !awaddr_held && !bvalid;
    assign wready  = (awaddr_held || aw_fire) && !bvalid;
    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;

    assign waddr_use = awaddr_held ? awaddr_latched : awaddr;
    assign lane_ofs  = waddr_use[1:0];
    assign addr_ok   = mem_pkg::addr_in_range(waddr_use);

    // shift into place, upper lanes fall off
    assign wdata_aligned.word = wdata << {lane_ofs, 3'b000};

    assign ram.en    = 1'b0;
    assign ram.addr  = waddr_use[mem_pkg::mem_addr_bits+1:2];
    assign ram.wstrb = 4'(wmask << lane_ofs);
    assign ram.wdata = wdata_aligned;
    assign ram.we    = w_fire && wen && addr_ok && (wmask != 4'b0000);

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            awaddr_latched <= awaddr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            awaddr_held <= 1'b0;
        end else begin
            case ({aw_fire, w_fire})
                2'b10:   awaddr_held <= 1'b1;
                2'b01:   awaddr_held <= 1'b0;
                // same-cycle aw and w needs no latch
                2'b11:   awaddr_held <= 1'b0;
                default: awaddr_held <= awaddr_held;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
            bresp  <= mem_pkg::resp_okay;
        end else begin
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end else if (w_fire) begin
                bvalid <= 1'b1;
                bresp  <= addr_ok ? mem_pkg::resp_okay : mem_pkg::resp_slverr;
            end
        end
    end

endmodule

//--- mem_read_port.sv
`timescale 1ns/1ps

module mem_read_port (
    input  logic        clk,
    input  logic        rst,

    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,

    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,

    mem_ram_if.ctrl     ram
);

    logic       busy;
    logic [1:0] delay_cnt;
    logic       ar_fire;
    logic       addr_ok;

    assign arready = !busy && !rvalid;
    assign ar_fire = arvalid && arready;
    assign addr_ok = mem_pkg::addr_in_range(araddr);

    // read-only use of the ram port
    assign ram.en    = ar_fire && addr_ok;
    assign ram.addr  = araddr[mem_pkg::mem_addr_bits+1:2];
    assign ram.we    = 1'b0;
    assign ram.wstrb = 4'b0000;
    assign ram.wdata = '0;

    // word is ready one edge after the accept
    always_ff @(posedge clk) begin
        if (busy && delay_cnt == 2'(mem_pkg::read_delay)) begin
            rdata <= (rresp == mem_pkg::resp_okay) ? ram.rdata : 32'h0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rresp <= mem_pkg::resp_okay;
        end else if (ar_fire) begin
            rresp <= addr_ok ? mem_pkg::resp_okay : mem_pkg::resp_slverr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid    <= 1'b0;
            busy      <= 1'b0;
            delay_cnt <= 2'b00;
        end else begin
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end else if (ar_fire) begin
                busy      <= 1'b1;
                delay_cnt <= 2'(mem_pkg::read_delay);
                rvalid    <= 1'b0;
            end else if (busy) begin
                if (delay_cnt != 2'b00) begin
                    delay_cnt <= delay_cnt - 2'b01;
                end else begin
                    // response held until rready
                    rvalid <= 1'b1;
                    busy   <= 1'b0;
                end
            end
        end
    end

endmodule

//--- mem_ram_if.sv
`timescale 1ns/1ps

interface mem_ram_if;

    logic                               en;
    logic [mem_pkg::mem_addr_bits-1:0]  addr;
    logic [31:0]                        rdata;
    logic                               we;
    logic [3:0]                         wstrb;
    mem_pkg::store_word_u               wdata;

    modport ctrl (
        output en,
        output addr,
        output we,
        output wstrb,
        output wdata,
        input  rdata
    );

    modport ram (
        input  en,
        input  addr,
        input  we,
        input  wstrb,
        input  wdata,
        output rdata
    );

endinterface

//--- mem_pkg.sv
package mem_pkg;

    // axi response codes
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // address map, 1 KiB of words
    localparam logic [31:0] mem_base      = 32'h8000_0000;
    localparam int          mem_words     = 256;
    localparam int          mem_addr_bits = 8;
    localparam logic [31:0] mem_bytes     = 32'(mem_words * 4);

    // wait cycles before rvalid
    localparam int read_delay = 1;

    // store word, whole or per byte lane
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] lanes;
    } store_word_u;

    function automatic logic addr_in_range(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - mem_base;
        // wraps to a large offset below the base
        return (addr >= mem_base) && (offset < mem_bytes);
    endfunction

endpackage
